// ==== design/configure_pkg.sv ====
package configure_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_vector = '0;
  localparam int fetchbuffer_depth = 4;  // Power of two so the pointers wrap on their own
  localparam int fetchbuffer_addr_bits = $clog2(fetchbuffer_depth);

  // Major opcodes the slice understands
  typedef enum logic [6:0] {
    opcode_op     = 7'b0110011,
    opcode_op_imm = 7'b0010011,
    opcode_lui    = 7'b0110111
  } opcode_type;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_type;

  typedef enum logic {
    fetch_idle,
    fetch_wait
  } fetch_state_type;

  typedef struct packed {
    logic mem_valid;
    logic [xlen-1:0] mem_addr;
  } mem_in_type;

  typedef struct packed {
    logic mem_ready;
    logic [31:0] mem_rdata;
  } mem_out_type;

  typedef struct packed {
    logic push;
    logic [31:0] instr;
    logic pop;
  } fetchbuffer_in_type;

  typedef struct packed {
    logic [31:0] instr;
    logic empty;
    logic space;  // At least one free entry
  } fetchbuffer_out_type;

  typedef struct packed {
    alu_op_type op;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [31:0] imm;
    logic use_imm;
    logic lui;
    logic wren;
    logic illegal;
  } decoder_out_type;

  typedef struct packed {
    logic [4:0] rs1;
    logic [4:0] rs2;
  } register_read_in_type;

  typedef struct packed {
    logic wren;
    logic [4:0] rd;
    logic [31:0] wdata;
  } register_write_in_type;

  typedef struct packed {
    logic [31:0] data1;
    logic [31:0] data2;
  } register_out_type;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [4:0] rd;
    logic [31:0] result;
    logic illegal;
  } retire_out_type;

endpackage

// ==== design/decoder.sv ====
`timescale 1ns/10ps

module decoder (
  input logic [31:0] instr,
  output configure_pkg::decoder_out_type decoder_out
);
  import configure_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_reg;
  logic f7_zero;
  logic f7_alt;  // Bit 30 form, sub and sra
  logic sel_ok;
  alu_op_type sel_op;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign is_reg = (instr[6:0] == opcode_op);
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt = (funct7 == 7'b0100000);

  // OP and OP-IMM share the funct3 selection
  always_comb begin
    case (funct3)
      3'b000: sel_op = (is_reg && f7_alt) ? alu_sub : alu_add;
      3'b001: sel_op = alu_sll;
      3'b010: sel_op = alu_slt;
      3'b011: sel_op = alu_sltu;
      3'b100: sel_op = alu_xor;
      3'b101: sel_op = f7_alt ? alu_sra : alu_srl;
      3'b110: sel_op = alu_or;
      default: sel_op = alu_and;
    endcase
    // Shifts check funct7 in both forms, the rest only in register form
    if (funct3 == 3'b001)
      sel_ok = f7_zero;
    else if (funct3 == 3'b101)
      sel_ok = f7_zero || f7_alt;
    else if (is_reg)
      sel_ok = f7_zero || (f7_alt && funct3 == 3'b000);
    else
      sel_ok = 1'b1;
  end

  always_comb begin
    decoder_out.op = sel_op;
    decoder_out.rs1 = instr[19:15];
    decoder_out.rs2 = instr[24:20];
    decoder_out.rd = instr[11:7];
    decoder_out.imm = '0;
    decoder_out.use_imm = 1'b0;
    decoder_out.lui = 1'b0;
    decoder_out.wren = 1'b0;
    decoder_out.illegal = 1'b1;
    case (instr[6:0])
      opcode_op: begin
        decoder_out.wren = sel_ok;
        decoder_out.illegal = !sel_ok;
      end
      opcode_op_imm: begin
        decoder_out.use_imm = 1'b1;
        if (funct3[1:0] == 2'b01)
          decoder_out.imm = {27'b0, instr[24:20]};  // shamt
        else
          decoder_out.imm = {{20{instr[31]}}, instr[31:20]};
        decoder_out.wren = sel_ok;
        decoder_out.illegal = !sel_ok;
      end
      opcode_lui: begin
        decoder_out.op = alu_add;
        decoder_out.imm = {instr[31:12], 12'b0};
        decoder_out.lui = 1'b1;
        decoder_out.wren = 1'b1;
        decoder_out.illegal = 1'b0;
      end
      default: begin
        decoder_out.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== design/register.sv ====
`timescale 1ns/10ps

module register (
  input logic clock,
  input logic rst_n,
  input configure_pkg::register_read_in_type register_rin,
  input configure_pkg::register_write_in_type register_win,
  output configure_pkg::register_out_type register_out
);
  import configure_pkg::*;

  logic [xlen-1:0] regs [0:31];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (register_win.wren && register_win.rd != 5'd0) begin
      regs[register_win.rd] <= register_win.wdata;  // x0 writes dropped
    end
  end

  // Asynchronous read
  assign register_out.data1 = (register_rin.rs1 == 5'd0) ? '0 : regs[register_rin.rs1];
  assign register_out.data2 = (register_rin.rs2 == 5'd0) ? '0 : regs[register_rin.rs2];

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input logic clock,
  input logic rst_n,
  input configure_pkg::fetchbuffer_out_type fetchbuffer_out,
  input configure_pkg::mem_out_type imem_out,
  output configure_pkg::mem_in_type imem_in,
  output logic push,
  output logic [31:0] instr
);
  import configure_pkg::*;

  fetch_state_type state;
  logic [xlen-1:0] pc;

  // Returned word goes straight into the buffer in the cycle of mem_ready
  assign push = (state == fetch_wait) && imem_out.mem_ready;
  assign instr = imem_out.mem_rdata;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= fetch_idle;
      pc <= reset_vector;
      imem_in.mem_valid <= 1'b0;
    end else begin
      imem_in.mem_valid <= 1'b0;  // Strobe lasts a single cycle
      case (state)
        fetch_idle: begin
          // Only ask when the answer is sure to find room
          if (fetchbuffer_out.space) begin
            imem_in.mem_valid <= 1'b1;
            imem_in.mem_addr <= pc;
            state <= fetch_wait;
          end
        end
        fetch_wait: begin
          if (imem_out.mem_ready) begin
            pc <= pc + xlen'(4);
            state <= fetch_idle;
          end
        end
        default: begin
          state <= fetch_idle;
        end
      endcase
    end
  end

endmodule

// ==== design/fetchbuffer.sv ====
`timescale 1ns/10ps

module fetchbuffer (
  input logic clock,
  input logic rst_n,
  input logic push,
  input logic [31:0] instr,
  input logic pop,
  output configure_pkg::fetchbuffer_out_type fetchbuffer_out
);
  import configure_pkg::*;

  logic [31:0] queue [0:fetchbuffer_depth-1];
  logic [fetchbuffer_addr_bits-1:0] rptr;
  logic [fetchbuffer_addr_bits-1:0] wptr;
  logic [fetchbuffer_addr_bits:0] count;  // One extra bit to tell full from empty

  always_ff @(posedge clock) begin
    if (push) begin
      queue[wptr] <= instr;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rptr <= '0;
      wptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign fetchbuffer_out.instr = queue[rptr];
  assign fetchbuffer_out.empty = (count == '0);
  assign fetchbuffer_out.space = (count != (fetchbuffer_addr_bits + 1)'(fetchbuffer_depth));

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
  input logic clock,
  input logic rst_n,
  input logic hold,
  input configure_pkg::fetchbuffer_out_type fetchbuffer_out,
  output logic pop,
  output configure_pkg::retire_out_type retire
);
  import configure_pkg::*;

  decoder_out_type decoder_out;
  register_read_in_type register_rin;
  register_write_in_type register_win;
  register_out_type register_out;
  logic [xlen-1:0] pc;  // Address of the next instruction to retire
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] result;

  assign pop = !fetchbuffer_out.empty && !hold;

  decoder decoder_comp (
    .instr(fetchbuffer_out.instr),
    .decoder_out(decoder_out)
  );

  register register_comp (
    .clock(clock),
    .rst_n(rst_n),
    .register_rin(register_rin),
    .register_win(register_win),
    .register_out(register_out)
  );

  assign register_rin.rs1 = decoder_out.rs1;
  assign register_rin.rs2 = decoder_out.rs2;
  assign op_a = register_out.data1;
  assign op_b = decoder_out.use_imm ? decoder_out.imm : register_out.data2;

  always_comb begin
    case (decoder_out.op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or: alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_sll: alu_result = op_a << op_b[4:0];
      alu_srl: alu_result = op_a >> op_b[4:0];
      alu_sra: alu_result = $signed(op_a) >>> op_b[4:0];
      default: alu_result = '0;
    endcase
  end

  // Illegal words retire with a zero result
  assign result = decoder_out.illegal ? '0 : (decoder_out.lui ? decoder_out.imm : alu_result);

  // Write lands at the same edge as the retire, so the next pop already sees it
  assign register_win.wren = pop && decoder_out.wren;
  assign register_win.rd = decoder_out.rd;
  assign register_win.wdata = result;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      pc <= reset_vector;
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= pop;
      if (pop) begin
        pc <= pc + xlen'(4);
        retire.pc <= pc;
        retire.rd <= decoder_out.rd;
        retire.result <= result;
        retire.illegal <= decoder_out.illegal;
      end
    end
  end

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/10ps

module cpu (
  input logic clock,
  input logic rst_n,
  input logic hold,
  input configure_pkg::mem_out_type imem_out,
  output configure_pkg::mem_in_type imem_in,
  output configure_pkg::retire_out_type retire
);
  import configure_pkg::*;

  fetchbuffer_in_type fetchbuffer_in;
  fetchbuffer_out_type fetchbuffer_out;

  fetch_stage fetch_stage_comp (
    .clock(clock),
    .rst_n(rst_n),
    .fetchbuffer_out(fetchbuffer_out),
    .imem_out(imem_out),
    .imem_in(imem_in),
    .push(fetchbuffer_in.push),
    .instr(fetchbuffer_in.instr)
  );

  fetchbuffer fetchbuffer_comp (
    .clock(clock),
    .rst_n(rst_n),
    .push(fetchbuffer_in.push),
    .instr(fetchbuffer_in.instr),
    .pop(fetchbuffer_in.pop),
    .fetchbuffer_out(fetchbuffer_out)
  );

  execute_stage execute_stage_comp (
    .clock(clock),
    .rst_n(rst_n),
    .hold(hold),
    .fetchbuffer_out(fetchbuffer_out),
    .pop(fetchbuffer_in.pop),
    .retire(retire)
  );

endmodule

// ==== test/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;
  import configure_pkg::*;

  localparam int period = 40;
  localparam int reg_ops_len = 14;
  localparam int imm_len = 10;
  localparam int x0_len = 7;
  localparam int hold_len = 12;
  localparam int program_len = reg_ops_len + imm_len + x0_len + hold_len;
  localparam int hold_cycles = 20;
  localparam int watchdog_cycles = program_len * 10 + 100;
  localparam logic [6:0] opc_imm = 7'h13;
  localparam logic [6:0] opc_load = 7'h03;
  localparam logic [31:0] nop = 32'h00000013;  // addi x0,x0,0

  logic clock;
  logic rst_n;
  logic hold;
  mem_in_type imem_in;
  mem_out_type imem_out;
  retire_out_type retire;

  logic [31:0] prog [$];
  logic [xlen-1:0] model_regs [0:31];
  logic [xlen-1:0] model_pc;
  logic [xlen-1:0] next_addr;
  integer seed = 32'h8e87da9f;
  int error_count = 0;
  int check_count = 0;
  int responses = 0;  // Words handed back by the memory model

  cpu dut (
    .clock(clock),
    .rst_n(rst_n),
    .hold(hold),
    .imem_out(imem_out),
    .imem_in(imem_in),
    .retire(retire)
  );

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [xlen-1:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog.size())
      return prog[idx];
    return nop;  // Past the end of the program
  endfunction

  task automatic load_program();
    // Register-register group with dependent operands
    prog.push_back(lui_word(20'h12345, 1));
    prog.push_back(i_type(opc_imm, 12'h678, 1, 3'd0, 1));
    prog.push_back(i_type(opc_imm, 12'hffd, 0, 3'd0, 2));
    prog.push_back(r_type(7'h00, 2, 1, 3'd0, 3));
    prog.push_back(r_type(7'h20, 1, 3, 3'd0, 4));
    prog.push_back(r_type(7'h00, 2, 3, 3'd7, 5));
    prog.push_back(r_type(7'h00, 4, 5, 3'd6, 6));
    prog.push_back(r_type(7'h00, 1, 6, 3'd4, 7));
    prog.push_back(r_type(7'h00, 1, 2, 3'd2, 8));
    prog.push_back(r_type(7'h00, 1, 2, 3'd3, 9));
    prog.push_back(i_type(opc_imm, 12'd7, 0, 3'd0, 10));
    prog.push_back(r_type(7'h00, 10, 1, 3'd1, 11));
    prog.push_back(r_type(7'h00, 10, 2, 3'd5, 12));
    prog.push_back(r_type(7'h20, 10, 2, 3'd5, 13));
    // Immediates
    prog.push_back(i_type(opc_imm, 12'h800, 1, 3'd0, 14));
    prog.push_back(i_type(opc_imm, 12'hfff, 14, 3'd0, 15));
    prog.push_back(i_type(opc_imm, 12'hffe, 2, 3'd2, 16));
    prog.push_back(i_type(opc_imm, 12'hfff, 2, 3'd3, 17));
    prog.push_back(i_type(opc_imm, 12'h004, 1, 3'd1, 18));
    prog.push_back(i_type(opc_imm, 12'd28, 2, 3'd5, 19));
    prog.push_back(i_type(opc_imm, 12'h401, 2, 3'd5, 20));  // srai
    prog.push_back(lui_word(20'hfffff, 21));
    prog.push_back(i_type(opc_imm, 12'h0f0, 1, 3'd7, 22));
    prog.push_back(i_type(opc_imm, 12'h7f0, 21, 3'd6, 23));
    // x0 writes, a load and a bad funct7
    prog.push_back(i_type(opc_imm, 12'd123, 0, 3'd0, 0));
    prog.push_back(r_type(7'h00, 2, 1, 3'd0, 0));
    prog.push_back(r_type(7'h00, 1, 0, 3'd0, 24));
    prog.push_back(i_type(opc_load, 12'h000, 1, 3'd2, 25));
    prog.push_back(r_type(7'h00, 0, 25, 3'd0, 26));
    prog.push_back(r_type(7'h01, 2, 1, 3'd0, 27));
    prog.push_back(r_type(7'h00, 0, 27, 3'd6, 28));
    for (int i = 0; i < hold_len; i++) begin
      prog.push_back(i_type(opc_imm, 12'(i + 1), 29, 3'd0, 29));  // Running sum in x29
    end
  endtask

  // ISA rules for the supported groups
  task automatic predict(input logic [31:0] w, output retire_out_type exp);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic is_reg;
    logic legal;
    f3 = w[14:12];
    f7 = w[31:25];
    is_reg = (w[6:0] == 7'h33);
    a = model_regs[w[19:15]];
    b = is_reg ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    case (f3)
      3'd0: r = (is_reg && w[30]) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (w[30])
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    case (w[6:0])
      7'h33: legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      7'h13: begin
        if (f3 == 3'd1)
          legal = (f7 == 7'h00);
        else if (f3 == 3'd5)
          legal = (f7 == 7'h00) || (f7 == 7'h20);
        else
          legal = 1'b1;
      end
      7'h37: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    if (w[6:0] == 7'h37)
      r = {w[31:12], 12'b0};
    if (!legal)
      r = '0;
    if (legal && w[11:7] != 5'd0)
      model_regs[w[11:7]] = r;
    exp.valid = 1'b1;
    exp.pc = model_pc;
    exp.rd = w[11:7];
    exp.result = r;
    exp.illegal = !legal;
  endtask

  task automatic check_retire(input retire_out_type exp, input retire_out_type act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $write("FAILED retire expected pc %h rd %h result %h illegal %h",
             exp.pc, exp.rd, exp.result, exp.illegal);
      $display(", actual pc %h rd %h result %h illegal %h",
               act.pc, act.rd, act.result, act.illegal);
    end
  endtask

  task automatic check_addr(input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED imem_in.mem_addr expected %h actual %h", exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Instruction memory, one request at a time, 1 to 4 cycles to answer
  always begin : memory_model
    logic [xlen-1:0] req_addr;
    int latency;
    @(negedge clock);
    if (rst_n === 1'b1 && imem_in.mem_valid === 1'b1) begin
      req_addr = imem_in.mem_addr;
      check_addr(next_addr, req_addr);
      next_addr = next_addr + 4;
      latency = 1 + ($unsigned($random(seed)) % 4);
      repeat (latency) @(negedge clock);
      imem_out.mem_rdata = fetch_word(req_addr);
      imem_out.mem_ready = 1'b1;
      responses++;
      @(negedge clock);
      imem_out.mem_ready = 1'b0;
    end
  end

  task automatic expect_retires(input int count);
    retire_out_type exp;
    for (int i = 0; i < count; i++) begin
      @(negedge clock);
      while (retire.valid !== 1'b1) @(negedge clock);
      predict(fetch_word(model_pc), exp);
      check_retire(exp, retire);
      model_pc += 4;
    end
  endtask

  task automatic test_reset();
    rst_n = 1'b0;
    repeat (4) begin
      @(posedge clock);
      @(negedge clock);
      check_bit("imem_in.mem_valid", 1'b0, imem_in.mem_valid);
      check_bit("retire.valid", 1'b0, retire.valid);
    end
    rst_n = 1'b1;
    @(negedge clock);  // First cycle out of reset
    check_bit("imem_in.mem_valid", 1'b1, imem_in.mem_valid);
    check_bit("retire.valid", 1'b0, retire.valid);
    check_addr(reset_vector, imem_in.mem_addr);
  endtask

  task automatic test_register_ops();
    expect_retires(reg_ops_len);
  endtask

  task automatic test_immediates();
    expect_retires(imm_len);
  endtask

  task automatic test_x0_and_illegal();
    expect_retires(x0_len);
  endtask

  task automatic test_hold();
    int buffered;
    expect_retires(4);
    hold = 1'b1;
    repeat (hold_cycles) begin
      @(negedge clock);
      check_bit("retire.valid", 1'b0, retire.valid);
      if (imem_in.mem_valid === 1'b1) begin
        // Words returned and not yet retired sit in the buffer
        buffered = responses - int'((model_pc - reset_vector) >> 2);
        check_count++;
        if (buffered >= fetchbuffer_depth) begin
          error_count++;
          $display("Fetch sent a request while the buffer already held %0d words",
                   buffered);
        end
      end
    end
    hold = 1'b0;
    expect_retires(hold_len - 4);
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    error_count++;
    $display("Watchdog expired after %0d cycles with tests still running", watchdog_cycles);
    finish_run();
  end

  initial begin
    rst_n = 1'b0;
    hold = 1'b0;
    imem_out = '0;
    next_addr = reset_vector;
    model_pc = reset_vector;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    load_program();
    test_reset();
    test_register_ops();
    test_immediates();
    test_x0_and_illegal();
    test_hold();
    finish_run();
  end

endmodule

// ==== flist.f ====
design/configure_pkg.sv
design/decoder.sv
design/register.sv
design/fetch_stage.sv
design/fetchbuffer.sv
design/execute_stage.sv
design/cpu.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_slice

sources:
  - design/configure_pkg.sv
  - design/decoder.sv
  - design/register.sv
  - design/fetch_stage.sv
  - design/fetchbuffer.sv
  - design/execute_stage.sv
  - design/cpu.sv
  - target: test
    files:
      - test/cpu_tb.sv
